// File: rtl/alu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu lane shared types
// widths, renaming constants and the execute and writeback bundles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package alu_pkg;

	localparam int XLEN = 64;
	localparam int RB = 2; // copy bits per architectural register.
	localparam int RP = 1 << RB;
	localparam int PHY_NUM = RP * 32; // physical registers on the read bus.

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] arch_reg_t;
	typedef logic [RB-1:0] copy_t;

	// copy index on top, architectural number below.
	typedef logic [5+RB-1:0] phy_reg_t;

	// one-hot alu operation, imm is the msb.
	typedef logic [9:0] alu_fun_t;

	localparam int FUN_IMM = 9;
	localparam int FUN_ADD = 8;
	localparam int FUN_SUB = 7;
	localparam int FUN_SLT = 6;
	localparam int FUN_XOR = 5;
	localparam int FUN_OR = 4;
	localparam int FUN_AND = 3;
	localparam int FUN_SLL = 2;
	localparam int FUN_SRL = 1;
	localparam int FUN_SRA = 0;

	typedef struct packed {
		alu_fun_t fun;
		logic is32w; // w form, 32-bit result sign-extended.
		logic is_usi; // unsigned compare.
		logic is_imm; // second operand is the immediate.
		logic is_shamt; // shift amount from the immediate.
		phy_reg_t rs1;
		phy_reg_t rs2;
		phy_reg_t rd;
		xlen_t pc;
		xlen_t imm;
	} exe_param_t;

	typedef struct packed {
		phy_reg_t rd;
		xlen_t res;
	} wb_t;

endpackage

// File: rtl/alu_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu decoder
// turns an rv64i alu instruction into execute parameters and
// maps its register fields onto renamed physical copies.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu_decoder (
	input alu_pkg::instr_t instr,
	input alu_pkg::xlen_t pc,
	input logic issue,
	input alu_pkg::copy_t [31:0] copy_ptr,
	output logic exe_valid,
	output alu_pkg::exe_param_t exe_param
);

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32 = 7'b0111011;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt; // instr[30], selects sub and sra.
	alu_pkg::arch_reg_t rd_arch;
	alu_pkg::arch_reg_t rs1_arch;
	alu_pkg::arch_reg_t rs2_arch;
	alu_pkg::xlen_t imm_i;
	alu_pkg::xlen_t imm_u;

	alu_pkg::alu_fun_t fun;
	logic is32w;
	logic is_usi;
	logic is_imm;
	logic is_shamt;
	logic use_imm_u;
	logic zero_rs1;
	logic dec_f3;
	alu_pkg::arch_reg_t rs1_sel;

	assign opcode = instr[6:0];
	assign rd_arch = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1_arch = instr[19:15];
	assign rs2_arch = instr[24:20];
	assign alt = instr[30];

	assign imm_i = {{(alu_pkg::XLEN-12){instr[31]}}, instr[31:20]};
	assign imm_u = {{(alu_pkg::XLEN-32){instr[31]}}, instr[31:12], 12'b0};

	always_comb begin
		fun = '0;
		is32w = 1'b0;
		is_usi = 1'b0;
		is_imm = 1'b0;
		is_shamt = 1'b0;
		use_imm_u = 1'b0;
		zero_rs1 = 1'b0;
		dec_f3 = 1'b0;

		case (opcode)
			OPC_LUI: begin
				fun[alu_pkg::FUN_ADD] = 1'b1; // x0 + imm.
				is_imm = 1'b1;
				use_imm_u = 1'b1;
				zero_rs1 = 1'b1;
			end
			OPC_AUIPC: begin
				fun[alu_pkg::FUN_IMM] = 1'b1; // pc + imm.
				use_imm_u = 1'b1;
			end
			OPC_OP_IMM: begin
				is_imm = 1'b1;
				dec_f3 = 1'b1;
			end
			OPC_OP: dec_f3 = 1'b1;
			OPC_OP_IMM_32: begin
				is_imm = 1'b1;
				is32w = 1'b1;
				dec_f3 = 1'b1;
			end
			OPC_OP_32: begin
				is32w = 1'b1;
				dec_f3 = 1'b1;
			end
			default: ; // not an alu op, dropped.
		endcase

		// w forms only define add, sub and the shifts.
		if (dec_f3) begin
			case (funct3)
				3'b000: begin
					if (alt && !is_imm) fun[alu_pkg::FUN_SUB] = 1'b1;
					else fun[alu_pkg::FUN_ADD] = 1'b1;
				end
				3'b001: begin
					fun[alu_pkg::FUN_SLL] = 1'b1;
					is_shamt = is_imm;
				end
				3'b010: fun[alu_pkg::FUN_SLT] = ~is32w;
				3'b011: begin
					fun[alu_pkg::FUN_SLT] = ~is32w;
					is_usi = 1'b1;
				end
				3'b100: fun[alu_pkg::FUN_XOR] = ~is32w;
				3'b101: begin
					if (alt) fun[alu_pkg::FUN_SRA] = 1'b1;
					else fun[alu_pkg::FUN_SRL] = 1'b1;
					is_shamt = is_imm;
				end
				3'b110: fun[alu_pkg::FUN_OR] = ~is32w;
				default: fun[alu_pkg::FUN_AND] = ~is32w;
			endcase
		end
	end

	assign rs1_sel = zero_rs1 ? 5'd0 : rs1_arch;

	// an undecoded funct3 leaves fun empty and drops the op too.
	assign exe_valid = issue & (|fun);

	always_comb begin
		exe_param.fun = fun;
		exe_param.is32w = is32w;
		exe_param.is_usi = is_usi;
		exe_param.is_imm = is_imm;
		exe_param.is_shamt = is_shamt;
		exe_param.rs1 = {copy_ptr[rs1_sel], rs1_sel};
		exe_param.rs2 = {copy_ptr[rs2_arch], rs2_arch};
		exe_param.rd = {alu_pkg::copy_t'(copy_ptr[rd_arch] + 1'b1), rd_arch}; // next copy.
		exe_param.pc = pc;
		exe_param.imm = use_imm_u ? imm_u : imm_i;
	end

endmodule

// File: rtl/reg_file_x.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// renamed integer register file
// rp copies per architectural register, rename pointers and
// a writeback bypass onto the flat read bus.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_file_x (
	input logic CLK,
	input logic rst,
	input logic wb_valid,
	input alu_pkg::wb_t wb,
	output logic [alu_pkg::XLEN*alu_pkg::PHY_NUM-1:0] regfile_x_read,
	output alu_pkg::copy_t [31:0] copy_ptr
);

	alu_pkg::xlen_t [alu_pkg::PHY_NUM-1:0] regs;
	alu_pkg::xlen_t [alu_pkg::PHY_NUM-1:0] read_bus;
	alu_pkg::copy_t [31:0] ptr;

	alu_pkg::arch_reg_t wb_arch;
	alu_pkg::copy_t wb_copy;
	logic wr_en;

	assign wb_arch = wb.rd[4:0];
	assign wb_copy = wb.rd[5 +: alu_pkg::RB];
	assign wr_en = wb_valid & (wb_arch != 5'd0); // x0 is never written.

	always_ff @(posedge CLK) begin
		if (rst) begin
			regs <= '0;
			ptr <= '0;
		end else if (wr_en) begin
			regs[wb.rd] <= wb.res;
			ptr[wb_arch] <= wb_copy; // writeback makes this copy current.
		end
	end

	// bypass the entry being written this cycle.
	always_comb begin
		read_bus = regs;
		copy_ptr = ptr;
		if (wr_en) begin
			read_bus[wb.rd] = wb.res;
			copy_ptr[wb_arch] = wb_copy;
		end
	end

	assign regfile_x_read = read_bus;

endmodule

// File: rtl/alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv64 integer alu
// add/sub, compare, logic and shifts with a registered
// writeback that a flush cancels.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu (
	input logic CLK,
	input logic rst,
	input logic flush,
	input logic exe_valid,
	input alu_pkg::exe_param_t exe_param,
	input logic [alu_pkg::XLEN*alu_pkg::PHY_NUM-1:0] regfile_x_read,
	output logic wb_valid,
	output alu_pkg::wb_t wb
);

	function automatic alu_pkg::xlen_t sext32(input alu_pkg::xlen_t v);
		return {{(alu_pkg::XLEN-32){v[31]}}, v[31:0]};
	endfunction

	alu_pkg::alu_fun_t fun;
	alu_pkg::xlen_t src1;
	alu_pkg::xlen_t src2;
	alu_pkg::xlen_t imm;

	alu_pkg::xlen_t add_op1;
	alu_pkg::xlen_t add_op2;
	alu_pkg::xlen_t add_sum;
	alu_pkg::xlen_t add_res;
	logic is_sub;

	alu_pkg::xlen_t log_op2;
	alu_pkg::xlen_t slt_res;
	logic lt;

	logic [5:0] shamt_src;
	logic [5:0] shamt;
	alu_pkg::xlen_t sl_raw;
	alu_pkg::xlen_t sl_res;
	logic signed [alu_pkg::XLEN:0] sr_op;
	logic signed [alu_pkg::XLEN:0] sr_full;
	alu_pkg::xlen_t sr_res;

	alu_pkg::xlen_t res;

	assign fun = exe_param.fun;
	assign imm = exe_param.imm;
	assign src1 = regfile_x_read[alu_pkg::XLEN*exe_param.rs1 +: alu_pkg::XLEN];
	assign src2 = regfile_x_read[alu_pkg::XLEN*exe_param.rs2 +: alu_pkg::XLEN];

	// adder, shared by auipc, add and sub.
	assign is_sub = fun[alu_pkg::FUN_SUB];
	assign add_op1 = fun[alu_pkg::FUN_IMM] ? exe_param.pc : src1;
	assign add_op2 = (fun[alu_pkg::FUN_IMM] | exe_param.is_imm) ? imm : src2;
	assign add_sum = add_op1 + (add_op2 ^ {alu_pkg::XLEN{is_sub}}) + alu_pkg::xlen_t'(is_sub);
	assign add_res = exe_param.is32w ? sext32(add_sum) : add_sum;

	assign log_op2 = exe_param.is_imm ? imm : src2;

	always_comb begin
		if (exe_param.is_usi) lt = src1 < log_op2;
		else lt = $signed(src1) < $signed(log_op2);
	end
	assign slt_res = alu_pkg::xlen_t'(lt);

	// w forms only see the low five bits of the amount.
	assign shamt_src = exe_param.is_shamt ? imm[5:0] : src2[5:0];
	assign shamt = {shamt_src[5] & ~exe_param.is32w, shamt_src[4:0]};

	assign sl_raw = src1 << shamt;
	assign sl_res = exe_param.is32w ? sext32(sl_raw) : sl_raw;

	// one extra bit carries the fill for srl and sra alike.
	always_comb begin
		if (exe_param.is32w)
			sr_op = {{(alu_pkg::XLEN-31){src1[31] & fun[alu_pkg::FUN_SRA]}}, src1[31:0]};
		else
			sr_op = {src1[alu_pkg::XLEN-1] & fun[alu_pkg::FUN_SRA], src1};
	end
	assign sr_full = sr_op >>> shamt;
	assign sr_res = exe_param.is32w ? sext32(sr_full[alu_pkg::XLEN-1:0])
		: sr_full[alu_pkg::XLEN-1:0];

	assign res = ({alu_pkg::XLEN{fun[alu_pkg::FUN_IMM] | fun[alu_pkg::FUN_ADD] | is_sub}} & add_res)
		| ({alu_pkg::XLEN{fun[alu_pkg::FUN_SLT]}} & slt_res)
		| ({alu_pkg::XLEN{fun[alu_pkg::FUN_XOR]}} & (src1 ^ log_op2))
		| ({alu_pkg::XLEN{fun[alu_pkg::FUN_OR]}} & (src1 | log_op2))
		| ({alu_pkg::XLEN{fun[alu_pkg::FUN_AND]}} & (src1 & log_op2))
		| ({alu_pkg::XLEN{fun[alu_pkg::FUN_SLL]}} & sl_res)
		| ({alu_pkg::XLEN{fun[alu_pkg::FUN_SRL] | fun[alu_pkg::FUN_SRA]}} & sr_res);

	always_ff @(posedge CLK) begin
		if (rst) wb_valid <= 1'b0;
		else wb_valid <= exe_valid & ~flush; // flushed op never writes back.
	end

	always_ff @(posedge CLK) begin
		wb.rd <= exe_param.rd;
		wb.res <= res;
	end

endmodule

// File: rtl/alu_lane_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu lane top
// decoder, renamed register file and alu of one integer lane.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module alu_lane_top (
	input logic CLK,
	input logic rst,
	input logic issue,
	input alu_pkg::instr_t instr,
	input alu_pkg::xlen_t pc,
	input logic flush,
	output logic wb_valid,
	output alu_pkg::wb_t wb
);

	logic exe_valid;
	alu_pkg::exe_param_t exe_param;
	alu_pkg::copy_t [31:0] copy_ptr;
	logic [alu_pkg::XLEN*alu_pkg::PHY_NUM-1:0] regfile_x_read;

	alu_decoder u_alu_decoder (
		.instr(instr),
		.pc(pc),
		.issue(issue),
		.copy_ptr(copy_ptr),
		.exe_valid(exe_valid),
		.exe_param(exe_param)
	);

	reg_file_x u_reg_file_x (
		.CLK(CLK),
		.rst(rst),
		.wb_valid(wb_valid),
		.wb(wb),
		.regfile_x_read(regfile_x_read),
		.copy_ptr(copy_ptr)
	);

	alu u_alu (
		.CLK(CLK),
		.rst(rst),
		.flush(flush),
		.exe_valid(exe_valid),
		.exe_param(exe_param),
		.regfile_x_read(regfile_x_read),
		.wb_valid(wb_valid),
		.wb(wb)
	);

endmodule

// File: tb/tb_alu_lane.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu lane testbench
// directed and random rv64i alu ops checked against a
// renaming reference model of the register file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_alu_lane;

	localparam logic [6:0] OP_LUI = 7'b0110111;
	localparam logic [6:0] OP_AUIPC = 7'b0010111;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] OP_REG = 7'b0110011;
	localparam logic [6:0] OP_IMM_W = 7'b0011011;
	localparam logic [6:0] OP_REG_W = 7'b0111011;
	localparam logic [6:0] SUB7 = 7'b0100000; // funct7 of sub and sra.
	localparam logic [34:0] BAD_OPC = {7'b1110011, 7'b1101111, 7'b1100011, 7'b0100011, 7'b0000011};
	localparam logic [14:0] BAD_F3W = {3'd7, 3'd6, 3'd4, 3'd3, 3'd2}; // no w form.

	typedef struct packed {
		alu_pkg::instr_t ins;
		alu_pkg::xlen_t pc;
	} pend_t;

	logic clk = 1'b0;
	logic rst;
	logic issue;
	alu_pkg::instr_t instr;
	alu_pkg::xlen_t pc;
	logic flush;
	logic wb_valid;
	alu_pkg::wb_t wb;

	alu_pkg::xlen_t model_reg [32];
	alu_pkg::copy_t model_ptr [32];
	pend_t pending [$]; // issued ops that must write back, oldest first.
	string test_name;

	alu_lane_top u_alu_lane_top (.CLK(clk), .rst(rst), .issue(issue), .instr(instr), .pc(pc),
		.flush(flush), .wb_valid(wb_valid), .wb(wb));

	initial begin
		forever #20 clk = ~clk;
	end

	function automatic alu_pkg::instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic alu_pkg::instr_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic alu_pkg::xlen_t sign_ext_w(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic logic is_legal(input alu_pkg::instr_t ins);
		case (ins[6:0])
			OP_LUI, OP_AUIPC, OP_IMM, OP_REG: return 1'b1;
			OP_IMM_W, OP_REG_W: return ins[14:12] inside {3'd0, 3'd1, 3'd5};
			default: return 1'b0;
		endcase
	endfunction

	// expected writeback from the architectural model and the renaming rule.
	function automatic alu_pkg::wb_t exe_ref(input alu_pkg::instr_t ins, input alu_pkg::xlen_t ipc);
		alu_pkg::wb_t r;
		alu_pkg::xlen_t a;
		alu_pkg::xlen_t b;
		alu_pkg::xlen_t imm_u;
		logic is_w;
		logic [5:0] sh;
		is_w = (ins[6:0] == OP_IMM_W) || (ins[6:0] == OP_REG_W);
		a = model_reg[ins[19:15]];
		b = (ins[5] == 1'b0) ? {{52{ins[31]}}, ins[31:20]} : model_reg[ins[24:20]];
		sh = is_w ? {1'b0, b[4:0]} : b[5:0];
		imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
		r.rd = {alu_pkg::copy_t'(model_ptr[ins[11:7]] + alu_pkg::copy_t'(1)), ins[11:7]};
		if (is_w && ins[14:12] == 3'd5) // right shifts of a word see only its low half.
			a = ins[30] ? sign_ext_w(a[31:0]) : {32'h0, a[31:0]};
		case (ins[14:12])
			3'd0: r.res = (ins[30] && ins[5]) ? a - b : a + b;
			3'd1: r.res = a << sh;
			3'd2: r.res = alu_pkg::xlen_t'($signed(a) < $signed(b));
			3'd3: r.res = alu_pkg::xlen_t'(a < b);
			3'd4: r.res = a ^ b;
			3'd5: begin
				if (ins[30]) r.res = $signed(a) >>> sh; // sign fill.
				else r.res = a >> sh;
			end
			3'd6: r.res = a | b;
			default: r.res = a & b;
		endcase
		if (ins[6:0] == OP_LUI) r.res = imm_u;
		else if (ins[6:0] == OP_AUIPC) r.res = ipc + imm_u;
		else if (is_w) r.res = sign_ext_w(r.res[31:0]);
		return r;
	endfunction

	function automatic alu_pkg::instr_t rand_instr();
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [2:0] f3w;
		logic [6:0] f7;
		logic [11:0] imm;
		rd = 5'($urandom % 8); // few registers, many dependences.
		rs1 = 5'($urandom % 8);
		rs2 = 5'($urandom % 8);
		f3 = 3'($urandom);
		f3w = ($urandom % 2 == 0) ? 3'd0 : (($urandom % 2 == 0) ? 3'd1 : 3'd5);
		f7 = ($urandom % 2 == 0) ? SUB7 : 7'd0;
		imm = 12'($urandom);
		case ($urandom % 8)
			0: return {20'($urandom), rd, OP_LUI};
			1: return {20'($urandom), rd, OP_AUIPC};
			2: begin
				if (f3 == 3'd1 || f3 == 3'd5) imm = {(f3 == 3'd5) ? f7[6:1] : 6'd0, imm[5:0]};
				return i_type(imm, rs1, f3, rd, OP_IMM);
			end
			3: return r_type((f3 == 3'd0 || f3 == 3'd5) ? f7 : 7'd0, rs2, rs1, f3, rd, OP_REG);
			4: begin
				if (f3w != 3'd0) imm = {(f3w == 3'd5) ? f7 : 7'd0, imm[4:0]};
				return i_type(imm, rs1, f3w, rd, OP_IMM_W);
			end
			5: return r_type((f3w == 3'd1) ? 7'd0 : f7, rs2, rs1, f3w, rd, OP_REG_W);
			6: return i_type(imm, rs1, f3, rd, BAD_OPC[7 * ($urandom % 5) +: 7]);
			default: return r_type(7'd0, rs2, rs1, BAD_F3W[3 * ($urandom % 5) +: 3], rd, OP_REG_W);
		endcase
	endfunction

	task automatic stop_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic chk_wb(input string name, input alu_pkg::wb_t exp, input alu_pkg::wb_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected rd %h res %h, actual rd %h res %h",
				name, exp.rd, exp.res, act.rd, act.res);
			stop_run();
		end
	endtask

	task automatic chk_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected wb_valid %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic send(input alu_pkg::instr_t ins, input logic fl);
		alu_pkg::xlen_t ipc;
		ipc = {$urandom, $urandom & 32'hffff_fffc};
		@(posedge clk);
		issue <= 1'b1;
		instr <= ins;
		pc <= ipc;
		flush <= fl;
		if (is_legal(ins) && !fl) pending.push_back(pend_t'({ins, ipc}));
	endtask

	// drop issue and wait until every pending writeback was seen.
	task automatic settle();
		int n;
		@(posedge clk);
		issue <= 1'b0;
		flush <= 1'b0;
		n = 0;
		while (pending.size() != 0) begin
			if (n == 20) begin
				$display("timeout while waiting for a writeback pulse");
				stop_run();
			end
			@(posedge clk);
			n++;
		end
		repeat (2) @(posedge clk); // a dropped op would pulse in here.
	endtask

	task automatic run_one(input alu_pkg::instr_t ins);
		send(ins, 1'b0);
		settle();
	endtask

	// compare at the falling edge, where the registered outputs are stable.
	initial begin : compare
		pend_t p;
		alu_pkg::wb_t exp;
		forever begin
			@(negedge clk);
			if (wb_valid !== 1'b0) begin
				if (pending.size() == 0) begin
					chk_valid(test_name, 1'b0, wb_valid);
				end else begin
					p = pending.pop_front();
					exp = exe_ref(p.ins, p.pc);
					chk_wb(test_name, exp, wb);
					if (exp.rd[4:0] != 5'd0) begin // x0 keeps zero and copy 0.
						model_reg[exp.rd[4:0]] = exp.res;
						model_ptr[exp.rd[4:0]] = exp.rd[5 +: alu_pkg::RB];
					end
				end
			end
		end
	end

	initial begin
		void'($urandom(19));
		rst = 1'b1;
		issue = 1'b0;
		instr = '0;
		pc = '0;
		flush = 1'b0;
		for (int i = 0; i < 32; i++) begin
			model_reg[i] = '0;
			model_ptr[i] = '0;
		end
		test_name = "reset";
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		run_one(r_type(7'd0, 5'd7, 5'd6, 3'd0, 5'd5, OP_REG)); // sources read zero, copy 1.
		run_one(i_type(12'hfff, 5'd0, 3'd0, 5'd1, OP_IMM)); // x1 all ones.

		test_name = "arith";
		run_one(i_type(12'd63, 5'd1, 3'd1, 5'd2, OP_IMM)); // x2 most negative.
		run_one(i_type(12'd1, 5'd1, 3'd5, 5'd3, OP_IMM)); // x3 most positive.
		run_one({20'h80000, 5'd4, OP_LUI});
		run_one({20'h12345, 5'd5, OP_AUIPC});
		run_one(r_type(7'd0, 5'd3, 5'd3, 3'd0, 5'd6, OP_REG));
		run_one(r_type(SUB7, 5'd3, 5'd2, 3'd0, 5'd7, OP_REG));
		run_one(r_type(7'd0, 5'd3, 5'd2, 3'd2, 5'd8, OP_REG));
		run_one(r_type(7'd0, 5'd3, 5'd2, 3'd3, 5'd9, OP_REG));
		run_one(r_type(7'd0, 5'd4, 5'd1, 3'd4, 5'd10, OP_REG));
		run_one(r_type(7'd0, 5'd3, 5'd4, 3'd6, 5'd11, OP_REG));
		run_one(r_type(7'd0, 5'd4, 5'd1, 3'd7, 5'd12, OP_REG));
		run_one(i_type(12'hfff, 5'd2, 3'd2, 5'd13, OP_IMM));
		run_one(i_type(12'hfff, 5'd3, 3'd3, 5'd14, OP_IMM));
		run_one(i_type(12'h800, 5'd4, 3'd7, 5'd15, OP_IMM));

		test_name = "shift";
		run_one(r_type(7'd0, 5'd3, 5'd1, 3'd1, 5'd16, OP_REG)); // amount 63.
		run_one(r_type(SUB7, 5'd3, 5'd2, 3'd5, 5'd17, OP_REG));
		run_one(i_type({6'b010000, 6'd12}, 5'd4, 3'd5, 5'd18, OP_IMM));
		run_one(i_type({7'd0, 5'd31}, 5'd1, 3'd1, 5'd19, OP_IMM_W));
		run_one(i_type({SUB7, 5'd4}, 5'd4, 3'd5, 5'd20, OP_IMM_W));
		run_one(r_type(7'd0, 5'd3, 5'd4, 3'd5, 5'd21, OP_REG_W)); // amount 63 seen as 31.
		run_one(r_type(7'd0, 5'd0, 5'd3, 3'd0, 5'd22, OP_REG_W));
		run_one(r_type(SUB7, 5'd1, 5'd4, 3'd0, 5'd23, OP_REG_W));

		test_name = "bypass";
		send(i_type(12'h123, 5'd0, 3'd0, 5'd9, OP_IMM), 1'b0);
		send(r_type(7'd0, 5'd9, 5'd9, 3'd0, 5'd10, OP_REG), 1'b0);
		settle();
		send(i_type(12'd1, 5'd9, 3'd0, 5'd9, OP_IMM), 1'b0);
		send(r_type(SUB7, 5'd1, 5'd9, 3'd0, 5'd9, OP_REG), 1'b0);
		settle();
		run_one(i_type(12'd5, 5'd1, 3'd0, 5'd0, OP_IMM)); // rd x0 still pulses.

		test_name = "flush";
		send(i_type(12'd7, 5'd0, 3'd0, 5'd3, OP_IMM), 1'b1);
		settle();
		run_one(i_type(12'd7, 5'd0, 3'd3, 5'd3, 7'b0000011)); // load, dropped.
		run_one(r_type(7'd0, 5'd1, 5'd1, 3'd4, 5'd3, OP_REG_W)); // no xorw.
		run_one(r_type(7'd0, 5'd0, 5'd3, 3'd0, 5'd24, OP_REG)); // old x3.

		test_name = "random";
		for (int i = 0; i < 300; i++) begin
			send(rand_instr(), 1'($urandom % 5 == 0));
			if ($urandom % 4 != 0) settle(); // else the next op follows back to back.
		end
		settle();

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: sim.f
rtl/alu_pkg.sv
rtl/alu_decoder.sv
rtl/reg_file_x.sv
rtl/alu.sv
rtl/alu_lane_top.sv
tb/tb_alu_lane.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the alu lane testbench with verilator and run it; $fatal gives a failing status
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_alu_lane -f sim.f -o sim_alu_lane &&
./obj_dir/sim_alu_lane || exit 1
